// ==== logic/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// one-word lines, 16 sets per way
`define CACHE_SETS 16
`define CIDX_W     4
`define COFF_W     2

`define ADDR_W     32
`define DATA_W     32

// tag is what is left above index and offset
`define CTAG_W     (`ADDR_W - `CIDX_W - `COFF_W)

`define CACHE_WAYS 2

`endif

// ==== logic/cache_pkg.sv ====
`include "cache_params.svh"

package cache_pkg;

    // access size of a cpu load or store
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10
    } size_t;

    typedef logic [`CTAG_W-1:0] ctag_t;
    typedef logic [`DATA_W-1:0] word_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        size_t              size;
        logic               wr;     // store when set
        word_t              wdata;  // store data, low bytes
    } cpu_req_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic               rd;     // held until ack
        logic               wr;     // held until ack
        logic [`ADDR_W-1:0] addr;   // word aligned
        word_t              wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ack;                 // single cycle
        word_t rdata;
    } mem_rsp_t;

endpackage

// ==== logic/way_ram.sv ====
`timescale 1ns/10ps

`include "cache_params.svh"

// one entry per set, sync write, async read
module way_ram #(
    parameter type payload_t = logic [7:0]
) (
    input  logic               clk,
    input  logic               we,
    input  logic [`CIDX_W-1:0] waddr,
    input  payload_t           wdata,
    input  logic [`CIDX_W-1:0] raddr,
    output payload_t           rdata
);

    payload_t mem [`CACHE_SETS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read sees the old entry until the write edge
    assign rdata = mem[raddr];

endmodule

// ==== logic/cache_way.sv ====
`timescale 1ns/10ps

`include "cache_params.svh"

module cache_way (
    input  logic               clk,
    input  logic               rst,
    input  logic [`ADDR_W-1:0] addr,
    input  cache_pkg::size_t   size,
    input  logic               rep,     // this way is the victim
    input  logic               we,
    input  logic               wp,      // fill
    input  logic               wm,      // whole word from memory
    input  logic               wd,
    input  cache_pkg::word_t   data_w,
    output logic               hit,
    output logic               need_r,  // dirty
    output cache_pkg::ctag_t   ctag_r,
    output cache_pkg::word_t   data_r,
    output cache_pkg::word_t   data_s
);

    import cache_pkg::*;

    ctag_t              addr_tag;
    logic [`CIDX_W-1:0] addr_idx;
    logic [`COFF_W-1:0] addr_off;

    logic [3:0] mask_a;
    word_t      data_a;
    logic [3:0] lane_mask;
    word_t      lane_data;
    word_t      data_x;

    logic [`CACHE_SETS-1:0] valid;
    logic [`CACHE_SETS-1:0] dirty;

    logic ctag_we;
    logic data_we;

    assign {addr_tag, addr_idx, addr_off} = addr;

    // store data replicated across lanes, mask picks the bytes
    always_comb begin
        case (size)
            SZ_BYTE: begin
                mask_a = 4'b0001 << addr_off;
                data_a = {4{data_w[7:0]}};
            end
            SZ_HALF: begin
                mask_a = addr_off[1] ? 4'b1100 : 4'b0011;
                data_a = {2{data_w[15:0]}};
            end
            default: begin
                mask_a = 4'b1111;
                data_a = data_w;
            end
        endcase
    end

    assign ctag_we = we & wp & rep;
    assign data_we = we & (wp ? rep : hit);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (we) begin
            if (wp & rep)
                valid[addr_idx] <= 1'b1;
            if (wp ? rep : hit)
                dirty[addr_idx] <= wd;
        end
    end

    way_ram #(.payload_t(ctag_t)) u_tag_ram (
        .clk   (clk),
        .we    (ctag_we),
        .waddr (addr_idx),
        .wdata (addr_tag),
        .raddr (addr_idx),
        .rdata (ctag_r)
    );

    assign lane_mask = wm ? 4'hf : mask_a;
    assign lane_data = wm ? data_w : data_a;   // refill writes the full word

    for (genvar l = 0; l < 4; l++) begin : g_lane
        way_ram #(.payload_t(logic [7:0])) u_data_ram (
            .clk   (clk),
            .we    (data_we & lane_mask[l]),
            .waddr (addr_idx),
            .wdata (lane_data[8*l +: 8]),
            .raddr (addr_idx),
            .rdata (data_x[8*l +: 8])
        );
    end

    assign data_r = valid[addr_idx] ? data_x : '0;
    assign hit    = valid[addr_idx] && (addr_tag == ctag_r);
    assign need_r = dirty[addr_idx];

    // load data moved down to bit 0
    assign data_s = data_r >> {addr_off, 3'b000};

endmodule

// ==== logic/cache_ctrl.sv ====
`timescale 1ns/10ps

`include "cache_params.svh"

module cache_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  cache_pkg::cpu_req_t cpu_req,
    output logic               busy,
    output cache_pkg::cpu_rsp_t cpu_rsp,
    output logic [`ADDR_W-1:0] addr,
    output cache_pkg::size_t   size,
    output logic [1:0]         rep,
    output logic               we,
    output logic               wp,
    output logic               wm,
    output logic               wd,
    output cache_pkg::word_t   wdata,
    input  logic [1:0]         hit,
    input  logic [1:0]         need_r,
    input  cache_pkg::ctag_t   ctag_r [2],
    input  cache_pkg::word_t   data_r [2],
    input  cache_pkg::word_t   data_s [2],
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp
);

    import cache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WB,
        S_REFILL,
        S_DONE
    } state_t;

    state_t   state;
    state_t   state_n;
    cpu_req_t req_q;
    word_t    rdata_q;

    logic [`CACHE_SETS-1:0] lru;   // names the way to evict next
    logic [`CIDX_W-1:0]     idx;
    logic                   accept;
    logic                   victim;
    logic                   hit_way;

    assign idx     = req_q.addr[`COFF_W +: `CIDX_W];
    assign busy    = (state == S_LOOKUP) || (state == S_WB) || (state == S_REFILL);
    assign accept  = req_valid && !busy;
    assign hit_way = hit[1];

    // lru starts at way 0 and flips on each fill,
    // so an empty way is always the one it names
    assign victim = lru[idx];
    assign rep    = victim ? 2'b10 : 2'b01;

    assign addr = req_q.addr;
    assign size = req_q.size;

    assign cpu_rsp.done  = (state == S_DONE);
    assign cpu_rsp.rdata = rdata_q;

    always_comb begin
        state_n = state;
        we      = 1'b0;
        wp      = 1'b0;
        wm      = 1'b0;
        wd      = 1'b0;
        wdata   = req_q.wdata;
        mem_req = '0;
        case (state)
            S_IDLE, S_DONE: begin
                state_n = accept ? S_LOOKUP : S_IDLE;
            end
            S_LOOKUP: begin
                if (|hit) begin
                    we      = req_q.wr;   // store hit marks the line dirty
                    wd      = 1'b1;
                    state_n = S_DONE;
                end else if (need_r[victim]) begin
                    state_n = S_WB;
                end else begin
                    state_n = S_REFILL;
                end
            end
            S_WB: begin
                mem_req.wr    = 1'b1;
                mem_req.addr  = {ctag_r[victim], idx, {`COFF_W{1'b0}}};
                mem_req.wdata = data_r[victim];
                if (mem_rsp.ack)
                    state_n = S_REFILL;
            end
            S_REFILL: begin
                mem_req.rd   = 1'b1;
                mem_req.addr = {req_q.addr[`ADDR_W-1:`COFF_W], {`COFF_W{1'b0}}};
                if (mem_rsp.ack) begin
                    we      = 1'b1;
                    wp      = 1'b1;
                    wm      = 1'b1;
                    wdata   = mem_rsp.rdata;
                    state_n = S_LOOKUP;   // replay as a hit
                end
            end
            default: state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            lru   <= '0;
        end else begin
            state <= state_n;
            if (state == S_LOOKUP && |hit)
                lru[idx] <= ~hit_way;
            else if (state == S_REFILL && mem_rsp.ack)
                lru[idx] <= ~victim;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            req_q <= cpu_req;
        if (state == S_LOOKUP && |hit)
            rdata_q <= req_q.wr ? '0 : data_s[hit_way];   // stores return zero
    end

endmodule

// ==== logic/dcache_top.sv ====
`timescale 1ns/10ps

`include "cache_params.svh"

module dcache_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  cache_pkg::cpu_req_t cpu_req,
    output logic                busy,
    output cache_pkg::cpu_rsp_t cpu_rsp,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp
);

    import cache_pkg::*;

    logic [`ADDR_W-1:0]     way_sel_addr;
    size_t                  size;
    logic [`CACHE_WAYS-1:0] rep;
    logic                   we;
    logic                   wp;
    logic                   wm;
    logic                   wd;
    word_t                  wdata;

    logic [`CACHE_WAYS-1:0] hit;
    logic [`CACHE_WAYS-1:0] need_r;
    ctag_t                  ctag_r [`CACHE_WAYS];
    word_t                  data_r [`CACHE_WAYS];
    word_t                  data_s [`CACHE_WAYS];

    cache_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .cpu_req   (cpu_req),
        .busy      (busy),
        .cpu_rsp   (cpu_rsp),
        .addr      (way_sel_addr),
        .size      (size),
        .rep       (rep),
        .we        (we),
        .wp        (wp),
        .wm        (wm),
        .wd        (wd),
        .wdata     (wdata),
        .hit       (hit),
        .need_r    (need_r),
        .ctag_r    (ctag_r),
        .data_r    (data_r),
        .data_s    (data_s),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    for (genvar g = 0; g < `CACHE_WAYS; g++) begin : g_way
        cache_way u_way (
            .clk    (clk),
            .rst    (rst),
            .addr   (way_sel_addr),
            .size   (size),
            .rep    (rep[g]),
            .we     (we),
            .wp     (wp),
            .wm     (wm),
            .wd     (wd),
            .data_w (wdata),
            .hit    (hit[g]),
            .need_r (need_r[g]),
            .ctag_r (ctag_r[g]),
            .data_r (data_r[g]),
            .data_s (data_s[g])
        );
    end

endmodule

// ==== tests/mem_responder.sv ====
`timescale 1ns/10ps

// word memory behind the cache, acks after 1 to 4 cycles
module mem_responder (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::mem_req_t mem_req,
    output cache_pkg::mem_rsp_t mem_rsp,
    output int                  wr_count,
    output int                  rd_count,
    output int                  rd_count_at_wr,  // reads seen when the last write-back landed
    output logic [31:0]         last_wr_addr,
    output logic [31:0]         last_wr_data,
    output logic [31:0]         last_rd_addr
);

    logic [31:0] image [256];
    logic [31:0] lcg_state;
    logic        pending;
    logic [1:0]  wait_left;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    initial begin
        logic [31:0] rnd;
        lcg_state      = 32'h5aa0;
        pending        = 1'b0;
        wait_left      = 2'd0;
        mem_rsp        = '0;
        wr_count       = 0;
        rd_count       = 0;
        rd_count_at_wr = 0;
        last_wr_addr   = '0;
        last_wr_data   = '0;
        last_rd_addr   = '0;
        for (int i = 0; i < 256; i++)
            image[i] = {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0] + 8'h31, i[7:0] ^ 8'hc3};
        forever begin
            @(posedge clk);
            #1;
            mem_rsp.ack = 1'b0;
            if (rst) begin
                pending = 1'b0;
            end else if (mem_req.rd || mem_req.wr) begin
                if (!pending) begin
                    rnd       = next_rand();
                    wait_left = rnd[17:16];
                    pending   = 1'b1;
                end
                if (wait_left == 2'd0) begin
                    pending     = 1'b0;
                    mem_rsp.ack = 1'b1;
                    if (mem_req.wr) begin
                        image[mem_req.addr[9:2]] = mem_req.wdata;
                        last_wr_addr   = mem_req.addr;
                        last_wr_data   = mem_req.wdata;
                        rd_count_at_wr = rd_count;
                        wr_count++;
                    end else begin
                        mem_rsp.rdata = image[mem_req.addr[9:2]];
                        last_rd_addr  = mem_req.addr;
                        rd_count++;
                    end
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

endmodule

// ==== tests/dcache_tb.sv ====
`timescale 1ns/10ps

module dcache_tb;

    import cache_pkg::*;

    localparam int NUM_REQ      = 600;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLE_LIMIT  = NUM_REQ * 20 + RESET_CYCLES;

    logic     clk = 1'b0;
    logic     rst;
    logic     req_valid;
    cpu_req_t cpu_req;
    logic     busy;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    int          wr_count;
    int          rd_count;
    int          rd_count_at_wr;
    logic [31:0] last_wr_addr;
    logic [31:0] last_wr_data;
    logic [31:0] last_rd_addr;

    // cpu view of memory plus shadow cache state
    logic [7:0] model_mem [1024];
    logic [3:0] sh_tag    [16][2];  // upper tag bits stay zero here
    logic       sh_valid  [16][2];
    logic       sh_dirty  [16][2];
    logic       sh_lru    [16];

    logic [31:0] lcg_state;
    int          error_count    = 0;
    int          check_count    = 0;
    int          cycle_count    = 0;
    int          strobe_cycles  = 0;
    int          overlap_cycles = 0;

    always #5 clk = ~clk;

    dcache_top uut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .cpu_req   (cpu_req),
        .busy      (busy),
        .cpu_rsp   (cpu_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    mem_responder u_mem (
        .clk            (clk),
        .rst            (rst),
        .mem_req        (mem_req),
        .mem_rsp        (mem_rsp),
        .wr_count       (wr_count),
        .rd_count       (rd_count),
        .rd_count_at_wr (rd_count_at_wr),
        .last_wr_addr   (last_wr_addr),
        .last_wr_data   (last_wr_data),
        .last_rd_addr   (last_rd_addr)
    );

    always @(negedge clk) begin
        if (mem_req.rd || mem_req.wr)
            strobe_cycles++;
        if (mem_req.rd && mem_req.wr)
            overlap_cycles++;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: requests still running after %0d cycles", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    function automatic logic [31:0] model_word(input logic [7:0] wi);
        return {model_mem[{wi, 2'd3}], model_mem[{wi, 2'd2}],
                model_mem[{wi, 2'd1}], model_mem[{wi, 2'd0}]};
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic run_request(input logic [7:0] wi, input size_t size, input logic [1:0] off,
                               input logic wr, input logic [31:0] wdata);
        logic [3:0]  idx;
        logic [3:0]  tag;
        logic        hit;
        logic        way;
        logic        wb_due;
        logic [7:0]  victim_wi;
        logic [31:0] exp_rdata;
        int          o;
        int          nbytes;
        int          cycles;
        int          wr0;
        int          rd0;
        int          strobe0;

        idx = wi[3:0];
        tag = wi[7:4];
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < 2; w++)
            if (sh_valid[idx][w] && sh_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        if (!hit)   // empty way 0, then empty way 1, then lru
            way = !sh_valid[idx][0] ? 1'b0 : !sh_valid[idx][1] ? 1'b1 : sh_lru[idx];
        wb_due    = !hit && sh_valid[idx][way] && sh_dirty[idx][way];
        victim_wi = {sh_tag[idx][way], idx};
        exp_rdata = wr ? 32'h0 : model_word(wi) >> {off, 3'b000};
        wr0       = wr_count;
        rd0       = rd_count;
        strobe0   = strobe_cycles;

        cpu_req.addr  = {22'h0, wi, off};
        cpu_req.size  = size;
        cpu_req.wr    = wr;
        cpu_req.wdata = wdata;
        req_valid     = 1'b1;
        cycles        = 0;
        do begin
            @(posedge clk);
            #1;
            req_valid = 1'b0;
            cycles++;
            compare("busy", {31'h0, busy}, {31'h0, !cpu_rsp.done});   // high until done
        end while (!cpu_rsp.done);

        compare("cpu_rsp.rdata", cpu_rsp.rdata, exp_rdata);
        if (hit) begin
            compare("hit latency", cycles, 2);
            compare("mem strobe cycles on hit", strobe_cycles - strobe0, 0);
        end else begin
            compare("write-back count", wr_count - wr0, wb_due ? 1 : 0);
            compare("refill read count", rd_count - rd0, 1);
            compare("refill mem_req.addr", last_rd_addr, {22'h0, wi, 2'b00});
            if (wb_due) begin
                compare("write-back mem_req.addr", last_wr_addr, {22'h0, victim_wi, 2'b00});
                compare("write-back mem_req.wdata", last_wr_data, model_word(victim_wi));
                compare("reads before write-back", rd_count_at_wr - rd0, 0);
            end
            sh_tag[idx][way]   = tag;
            sh_valid[idx][way] = 1'b1;
            sh_dirty[idx][way] = 1'b0;
        end
        compare("mem rd and wr together", overlap_cycles, 0);

        if (wr) begin
            o      = {30'h0, off};
            nbytes = (size == SZ_BYTE) ? 1 : (size == SZ_HALF) ? 2 : 4;
            for (int b = 0; b < 4; b++)
                if (b >= o && b < o + nbytes)
                    model_mem[{wi, b[1:0]}] = wdata[8*(b-o) +: 8];
            sh_dirty[idx][way] = 1'b1;
        end
        sh_lru[idx] = ~way;
    endtask

    initial begin
        logic [31:0] rnd;
        logic [7:0]  kind;
        size_t       size;
        logic [1:0]  off;

        rst       = 1'b1;
        req_valid = 1'b0;
        cpu_req   = '0;
        lcg_state = 32'h5aa0;
        for (int s = 0; s < 16; s++) begin
            for (int w = 0; w < 2; w++) begin
                sh_tag[s][w]   = 4'h0;
                sh_valid[s][w] = 1'b0;
                sh_dirty[s][w] = 1'b0;
            end
            sh_lru[s] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int a = 0; a < 1024; a++)
            model_mem[a] = u_mem.image[a >> 2][8*(a % 4) +: 8];
        compare("busy/done/mem rd/mem wr after reset",
                {28'h0, busy, cpu_rsp.done, mem_req.rd, mem_req.wr}, 32'h0);

        for (int n = 0; n < NUM_REQ; n++) begin
            rnd  = next_rand();
            kind = rnd[31:24] % 8'd3;
            case (kind)
                8'd0: begin
                    size = SZ_BYTE;
                    off  = rnd[13:12];
                end
                8'd1: begin
                    size = SZ_HALF;
                    off  = {rnd[12], 1'b0};
                end
                default: begin
                    size = SZ_WORD;
                    off  = 2'b00;
                end
            endcase
            run_request(rnd[23:16], size, off, rnd[8], next_rand());
        end

        $display("%0d requests, %0d checks, %0d errors", NUM_REQ, check_count, error_count);
        if (error_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== dcache_top.f ====
+incdir+logic
logic/cache_pkg.sv
logic/way_ram.sv
logic/cache_way.sv
logic/cache_ctrl.sv
logic/dcache_top.sv
tests/mem_responder.sv
tests/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module dcache_tb -f dcache_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vdcache_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
